//--- design/axi_bus_pkg.sv
//////////////////////////////////////////////////
// AXI3 general-purpose port definitions
// Widths, default ID width and response codes
// shared by the bridge and the top level
//////////////////////////////////////////////////

`default_nettype none

package axi_bus_pkg;

  // Data and address widths of the GP port
  localparam int AXI_DW = 32;
  localparam int AXI_AW = 32;

  // GP port ID width, overridable per instance
  localparam int AXI_IW_DEF = 12;

  // Only the codes this bridge can return
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axi_resp_e;

endpackage

`default_nettype wire

//--- design/sys_bus_pkg.sv
//////////////////////////////////////////////////
// System bus definitions
// Widths, address map regions and the address
// word as seen by the interconnect and the slaves
//////////////////////////////////////////////////

`default_nettype none

package sys_bus_pkg;

  localparam int SYS_DW = 32;
  localparam int SYS_AW = 32;
  // One select bit per byte lane
  localparam int SYS_SW = 4;

  // Address map, one region per peripheral
  typedef enum logic [3:0] {
    REG_HK  = 4'd0,
    REG_BUF = 4'd1
  } sys_region_e;

  // Region in bits 23:20, byte offset below it
  typedef struct packed {
    logic [7:0]  rsvd;
    sys_region_e region;
    logic [19:0] offset;
  } sys_addr_split_t;

  typedef union packed {
    logic [SYS_AW-1:0] flat;
    sys_addr_split_t   split;
  } sys_addr_u;

  // Board ID readable at housekeeping offset 0
  localparam logic [SYS_DW-1:0] HK_ID = 32'h5053_0001;

endpackage

`default_nettype wire

//--- design/sys_bus_if.sv
//////////////////////////////////////////////////
// System bus between the bridge, the interconnect
// and the peripherals. One strobe per access,
// answered one cycle later by ack or err
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

interface sys_bus_if (
  input logic clk,
  input logic rst
);
  import sys_bus_pkg::*;

  sys_addr_u         addr;
  logic [SYS_DW-1:0] wdata;
  logic [SYS_SW-1:0] sel;
  logic              wen;
  logic              ren;
  logic [SYS_DW-1:0] rdata;
  logic              ack;
  logic              err;

  // Bus master side
  modport m (
    input  clk, rst,
    output addr, wdata, sel, wen, ren,
    input  rdata, ack, err
  );

  // Peripheral side
  modport s (
    input  clk, rst,
    input  addr, wdata, sel, wen, ren,
    output rdata, ack, err
  );

endinterface

`default_nettype wire

//--- design/axi4_slave.sv
//////////////////////////////////////////////////
// AXI3 single-beat slave acting as system bus
// master. Each AXI transfer becomes one wen or ren
// strobe, the answer is returned on B or R
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module axi4_slave #(
  parameter int ID_W = axi_bus_pkg::AXI_IW_DEF
) (
  input  logic                            clk_i,
  input  logic                            rst_i,
  // Write address
  input  logic                            awvalid_i,
  output logic                            awready_o,
  input  logic [ID_W-1:0]                 awid_i,
  input  logic [axi_bus_pkg::AXI_AW-1:0]  awaddr_i,
  // Write data
  input  logic                            wvalid_i,
  output logic                            wready_o,
  input  logic [axi_bus_pkg::AXI_DW-1:0]  wdata_i,
  input  logic [axi_bus_pkg::AXI_DW/8-1:0] wstrb_i,
  // Write response
  output logic                            bvalid_o,
  input  logic                            bready_i,
  output logic [ID_W-1:0]                 bid_o,
  output axi_bus_pkg::axi_resp_e          bresp_o,
  // Read address
  input  logic                            arvalid_i,
  output logic                            arready_o,
  input  logic [ID_W-1:0]                 arid_i,
  input  logic [axi_bus_pkg::AXI_AW-1:0]  araddr_i,
  // Read data
  output logic                            rvalid_o,
  input  logic                            rready_i,
  output logic [ID_W-1:0]                 rid_o,
  output logic [axi_bus_pkg::AXI_DW-1:0]  rdata_o,
  output axi_bus_pkg::axi_resp_e          rresp_o,
  output logic                            rlast_o,
  // System bus
  sys_bus_if.m                            bus
);
  import axi_bus_pkg::*;

  typedef enum logic [1:0] {ST_INIT, ST_IDLE, ST_WAIT, ST_RESP} state_t;

  state_t              state;
  logic                aw_hold, w_hold, ar_hold;
  logic                aw_hs, w_hs, ar_hs;
  logic                issue_wr, issue_rd;
  logic                is_wr_q;
  logic [ID_W-1:0]     awid_q, arid_q, id_q;
  logic [AXI_AW-1:0]   awaddr_q, araddr_q;
  logic [AXI_DW-1:0]   wdata_q, rdata_q;
  logic [AXI_DW/8-1:0] wstrb_q;
  axi_resp_e           resp_q;

  //////////////////////////////////////////////////
  // AXI channel capture
  //////////////////////////////////////////////////

  // Accept beats only while idle and not already held
  assign awready_o = (state == ST_IDLE) && !aw_hold;
  assign wready_o  = (state == ST_IDLE) && !w_hold;
  assign arready_o = (state == ST_IDLE) && !ar_hold;

  assign aw_hs = awvalid_i && awready_o;
  assign w_hs  = wvalid_i && wready_o;
  assign ar_hs = arvalid_i && arready_o;

  // Write wins when both directions are pending
  assign issue_wr = (state == ST_IDLE) && aw_hold && w_hold;
  assign issue_rd = (state == ST_IDLE) && ar_hold && !(aw_hold && w_hold);

  //////////////////////////////////////////////////
  // Control FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state    <= ST_INIT;
      aw_hold  <= 1'b0;
      w_hold   <= 1'b0;
      ar_hold  <= 1'b0;
      is_wr_q  <= 1'b0;
      bvalid_o <= 1'b0;
      rvalid_o <= 1'b0;
      bus.wen  <= 1'b0;
      bus.ren  <= 1'b0;
    end else begin
      bus.wen <= 1'b0;
      bus.ren <= 1'b0;

      if (issue_wr) begin
        aw_hold <= 1'b0;
        w_hold  <= 1'b0;
      end else begin
        if (aw_hs) aw_hold <= 1'b1;
        if (w_hs)  w_hold  <= 1'b1;
      end

      if (issue_rd) begin
        ar_hold <= 1'b0;
      end else if (ar_hs) begin
        ar_hold <= 1'b1;
      end

      case (state)
        ST_INIT: state <= ST_IDLE;
        ST_IDLE: begin
          if (issue_wr) begin
            bus.wen <= 1'b1;
            is_wr_q <= 1'b1;
            state   <= ST_WAIT;
          end else if (issue_rd) begin
            bus.ren <= 1'b1;
            is_wr_q <= 1'b0;
            state   <= ST_WAIT;
          end
        end
        ST_WAIT: begin
          // Peripheral or interconnect answers one cycle after the strobe
          if (bus.ack || bus.err) begin
            if (is_wr_q) bvalid_o <= 1'b1;
            else         rvalid_o <= 1'b1;
            state <= ST_RESP;
          end
        end
        ST_RESP: begin
          if ((bvalid_o && bready_i) || (rvalid_o && rready_i)) begin
            bvalid_o <= 1'b0;
            rvalid_o <= 1'b0;
            state    <= ST_IDLE;
          end
        end
        default: state <= ST_INIT;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Payload registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      awid_q   <= awid_i;
      awaddr_q <= awaddr_i;
    end
    if (w_hs) begin
      wdata_q <= wdata_i;
      wstrb_q <= wstrb_i;
    end
    if (ar_hs) begin
      arid_q   <= arid_i;
      araddr_q <= araddr_i;
    end

    if (issue_wr) begin
      bus.addr.flat <= awaddr_q;
      bus.wdata     <= wdata_q;
      bus.sel       <= wstrb_q;
      id_q          <= awid_q;
    end else if (issue_rd) begin
      bus.addr.flat <= araddr_q;
      bus.sel       <= '1;
      id_q          <= arid_q;
    end

    if ((state == ST_WAIT) && (bus.ack || bus.err)) begin
      resp_q  <= bus.err ? SLVERR : OKAY;
      rdata_q <= bus.rdata;
    end
  end

  assign bid_o   = id_q;
  assign bresp_o = resp_q;
  assign rid_o   = id_q;
  assign rresp_o = resp_q;
  assign rdata_o = rdata_q;
  // Single-beat bursts only
  assign rlast_o = 1'b1;

endmodule

`default_nettype wire

//--- design/sys_bus_interconnect.sv
//////////////////////////////////////////////////
// Region decoder between the bridge and the
// peripherals. Strobes go to the addressed slave,
// unmapped regions are answered with err
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module sys_bus_interconnect (
  sys_bus_if.s bus_m,
  sys_bus_if.m bus_hk,
  sys_bus_if.m bus_buf
);
  import sys_bus_pkg::*;

  logic sel_hk;
  logic sel_buf;
  logic err_q;

  //////////////////////////////////////////////////
  // Request path, combinational
  //////////////////////////////////////////////////

  assign sel_hk  = (bus_m.addr.split.region == REG_HK);
  assign sel_buf = (bus_m.addr.split.region == REG_BUF);

  // Address and data fan out, only the strobes are gated
  assign bus_hk.addr  = bus_m.addr;
  assign bus_hk.wdata = bus_m.wdata;
  assign bus_hk.sel   = bus_m.sel;
  assign bus_hk.wen   = bus_m.wen && sel_hk;
  assign bus_hk.ren   = bus_m.ren && sel_hk;

  assign bus_buf.addr  = bus_m.addr;
  assign bus_buf.wdata = bus_m.wdata;
  assign bus_buf.sel   = bus_m.sel;
  assign bus_buf.wen   = bus_m.wen && sel_buf;
  assign bus_buf.ren   = bus_m.ren && sel_buf;

  //////////////////////////////////////////////////
  // Response path
  //////////////////////////////////////////////////

  // Unmapped access, answer with the same latency as a peripheral
  always_ff @(posedge bus_m.clk) begin
    if (bus_m.rst) begin
      err_q <= 1'b0;
    end else begin
      err_q <= (bus_m.wen || bus_m.ren) && !(sel_hk || sel_buf);
    end
  end

  // Only the addressed slave acks, so its ack picks the data
  always_comb begin
    if (bus_hk.ack) begin
      bus_m.rdata = bus_hk.rdata;
    end else if (bus_buf.ack) begin
      bus_m.rdata = bus_buf.rdata;
    end else begin
      bus_m.rdata = '0;
    end
  end

  assign bus_m.ack = bus_hk.ack || bus_buf.ack;
  assign bus_m.err = err_q || bus_hk.err || bus_buf.err;

endmodule

`default_nettype wire

//--- design/housekeeping_regs.sv
//////////////////////////////////////////////////
// Housekeeping registers: ID, LED, scratch and a
// free-running cycle counter on the system bus
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module housekeeping_regs (
  sys_bus_if.s       bus,
  output logic [7:0] led_o
);
  import sys_bus_pkg::*;

  // Byte offsets within the region
  localparam logic [19:0] OFF_ID   = 20'h0_0000;
  localparam logic [19:0] OFF_LED  = 20'h0_0004;
  localparam logic [19:0] OFF_SCR  = 20'h0_0008;
  localparam logic [19:0] OFF_CNT  = 20'h0_000C;

  logic [7:0]        led_q;
  logic [SYS_DW-1:0] scratch_q;
  logic [SYS_DW-1:0] counter_q;

  always_ff @(posedge bus.clk) begin
    if (bus.rst) begin
      led_q     <= '0;
      scratch_q <= '0;
      counter_q <= '0;
      bus.ack   <= 1'b0;
    end else begin
      counter_q <= counter_q + 1'b1;
      bus.ack   <= bus.wen || bus.ren;
      // Whole-word writes, sel is not used here
      if (bus.wen) begin
        case (bus.addr.split.offset)
          OFF_LED: led_q     <= bus.wdata[7:0];
          OFF_SCR: scratch_q <= bus.wdata;
          default: ;
        endcase
      end
    end
  end

  // Read data captured at the strobe
  always_ff @(posedge bus.clk) begin
    if (bus.ren) begin
      case (bus.addr.split.offset)
        OFF_ID:  bus.rdata <= HK_ID;
        OFF_LED: bus.rdata <= {{(SYS_DW-8){1'b0}}, led_q};
        OFF_SCR: bus.rdata <= scratch_q;
        OFF_CNT: bus.rdata <= counter_q;
        default: bus.rdata <= '0;
      endcase
    end
  end

  assign bus.err = 1'b0;
  assign led_o   = led_q;

endmodule

`default_nettype wire

//--- design/buffer_ram.sv
//////////////////////////////////////////////////
// Word buffer RAM on the system bus
// Byte-lane writes, registered reads, the index
// wraps at the RAM depth
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module buffer_ram #(
  parameter int BUF_WORDS = 64
) (
  sys_bus_if.s bus
);
  import sys_bus_pkg::*;

  localparam int IDX_W = $clog2(BUF_WORDS);

  logic [SYS_DW-1:0] mem [BUF_WORDS];
  logic [IDX_W-1:0]  word_idx;

  // Word index from the byte offset
  assign word_idx = IDX_W'(bus.addr.split.offset[19:2] % BUF_WORDS);

  always_ff @(posedge bus.clk) begin
    if (bus.wen) begin
      for (int b = 0; b < SYS_SW; b++) begin
        if (bus.sel[b]) mem[word_idx][8*b +: 8] <= bus.wdata[8*b +: 8];
      end
    end
    if (bus.ren) begin
      bus.rdata <= mem[word_idx];
    end
  end

  always_ff @(posedge bus.clk) begin
    if (bus.rst) begin
      bus.ack <= 1'b0;
    end else begin
      bus.ack <= bus.wen || bus.ren;
    end
  end

  assign bus.err = 1'b0;

endmodule

`default_nettype wire

//--- design/ps_bus_top.sv
//////////////////////////////////////////////////
// Processor-side bus top level. AXI3 GP port in,
// bridge to the system bus, region decode and the
// housekeeping and buffer peripherals behind it
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ps_bus_top #(
  parameter int ID_W      = axi_bus_pkg::AXI_IW_DEF,
  parameter int BUF_WORDS = 64
) (
  input  logic                             clk_i,
  input  logic                             rst_i,
  // Write address
  input  logic                             awvalid_i,
  output logic                             awready_o,
  input  logic [ID_W-1:0]                  awid_i,
  input  logic [axi_bus_pkg::AXI_AW-1:0]   awaddr_i,
  // Write data
  input  logic                             wvalid_i,
  output logic                             wready_o,
  input  logic [axi_bus_pkg::AXI_DW-1:0]   wdata_i,
  input  logic [axi_bus_pkg::AXI_DW/8-1:0] wstrb_i,
  // Write response
  output logic                             bvalid_o,
  input  logic                             bready_i,
  output logic [ID_W-1:0]                  bid_o,
  output axi_bus_pkg::axi_resp_e           bresp_o,
  // Read address
  input  logic                             arvalid_i,
  output logic                             arready_o,
  input  logic [ID_W-1:0]                  arid_i,
  input  logic [axi_bus_pkg::AXI_AW-1:0]   araddr_i,
  // Read data
  output logic                             rvalid_o,
  input  logic                             rready_i,
  output logic [ID_W-1:0]                  rid_o,
  output logic [axi_bus_pkg::AXI_DW-1:0]   rdata_o,
  output axi_bus_pkg::axi_resp_e           rresp_o,
  output logic                             rlast_o,
  // Board LEDs
  output logic [7:0]                       led_o
);

  //////////////////////////////////////////////////
  // System bus segments
  //////////////////////////////////////////////////

  sys_bus_if bus_m   (.clk (clk_i), .rst (rst_i));
  sys_bus_if bus_hk  (.clk (clk_i), .rst (rst_i));
  sys_bus_if bus_buf (.clk (clk_i), .rst (rst_i));

  // AXI to system bus bridge
  axi4_slave #(
    .ID_W (ID_W)
  ) u_axi_slave (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .awvalid_i (awvalid_i),
    .awready_o (awready_o),
    .awid_i    (awid_i),
    .awaddr_i  (awaddr_i),
    .wvalid_i  (wvalid_i),
    .wready_o  (wready_o),
    .wdata_i   (wdata_i),
    .wstrb_i   (wstrb_i),
    .bvalid_o  (bvalid_o),
    .bready_i  (bready_i),
    .bid_o     (bid_o),
    .bresp_o   (bresp_o),
    .arvalid_i (arvalid_i),
    .arready_o (arready_o),
    .arid_i    (arid_i),
    .araddr_i  (araddr_i),
    .rvalid_o  (rvalid_o),
    .rready_i  (rready_i),
    .rid_o     (rid_o),
    .rdata_o   (rdata_o),
    .rresp_o   (rresp_o),
    .rlast_o   (rlast_o),
    .bus       (bus_m)
  );

  sys_bus_interconnect u_interconnect (
    .bus_m   (bus_m),
    .bus_hk  (bus_hk),
    .bus_buf (bus_buf)
  );

  //////////////////////////////////////////////////
  // Peripherals
  //////////////////////////////////////////////////

  housekeeping_regs u_hk (
    .bus   (bus_hk),
    .led_o (led_o)
  );

  buffer_ram #(
    .BUF_WORDS (BUF_WORDS)
  ) u_buf (
    .bus (bus_buf)
  );

endmodule

`default_nettype wire

//--- dv/ps_bus_tb.sv
//////////////////////////////////////////////////
// Testbench for the processor-side bus bridge
// Random single-beat AXI traffic from a fixed seed,
// checked against a model of the registers and RAM
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ps_bus_tb;
  import axi_bus_pkg::*;

  localparam int ID_W      = AXI_IW_DEF;
  localparam int BUF_WORDS = 64;
  localparam int TIMEOUT   = 50;

  // Board ID value of the housekeeping block
  localparam logic [31:0] ID_VALUE = 32'h5053_0001;

  // Channel codes for the handshake wait
  localparam int CH_AW = 0;
  localparam int CH_W  = 1;
  localparam int CH_AR = 2;
  localparam int CH_B  = 3;
  localparam int CH_R  = 4;

  logic            clk;
  logic            rst;
  logic            awvalid, awready, wvalid, wready, bvalid, bready;
  logic            arvalid, arready, rvalid, rready, rlast;
  logic [ID_W-1:0] awid, bid, arid, rid;
  logic [31:0]     awaddr, araddr, wdata, rdata;
  logic [3:0]      wstrb;
  logic [7:0]      led;
  axi_resp_e       bresp, rresp;

  int          cyc;
  int          errors;
  int          checks;
  int          tests_run;
  int          tests_failed;
  int          err_at_start;
  string       cur_test;
  logic [31:0] ram_model [BUF_WORDS];
  logic [7:0]  led_model;
  logic [31:0] scratch_model;

  ps_bus_top #(
    .ID_W      (ID_W),
    .BUF_WORDS (BUF_WORDS)
  ) DUT (
    .clk_i     (clk),
    .rst_i     (rst),
    .awvalid_i (awvalid),
    .awready_o (awready),
    .awid_i    (awid),
    .awaddr_i  (awaddr),
    .wvalid_i  (wvalid),
    .wready_o  (wready),
    .wdata_i   (wdata),
    .wstrb_i   (wstrb),
    .bvalid_o  (bvalid),
    .bready_i  (bready),
    .bid_o     (bid),
    .bresp_o   (bresp),
    .arvalid_i (arvalid),
    .arready_o (arready),
    .arid_i    (arid),
    .araddr_i  (araddr),
    .rvalid_o  (rvalid),
    .rready_i  (rready),
    .rid_o     (rid),
    .rdata_o   (rdata),
    .rresp_o   (rresp),
    .rlast_o   (rlast),
    .led_o     (led)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Edge count for timing handshakes
  always @(posedge clk) cyc <= cyc + 1;

  //////////////////////////////////////////////////
  // Checks and reporting
  //////////////////////////////////////////////////

  task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      $display("error %s: %s expected %h actual %h", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond === 1'b1) else begin
      $display("failure in %s: %s", cur_test, what);
      errors++;
    end
  endtask

  task automatic start_test(input string name);
    cur_test     = name;
    err_at_start = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors != err_at_start) tests_failed++;
    $display("test %s: done, %0d errors", cur_test, errors - err_at_start);
  endtask

  task automatic stuck(input string what);
    $display("timeout in %s: %s", cur_test, what);
    $display("Something failed");
    $finish;
  endtask

  //////////////////////////////////////////////////
  // AXI channel helpers
  //////////////////////////////////////////////////

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  function automatic logic chan_high(input int chan);
    case (chan)
      CH_AW:   return awready;
      CH_W:    return wready;
      CH_AR:   return arready;
      CH_B:    return bvalid;
      default: return rvalid;
    endcase
  endfunction

  // Sampled at the falling edge where all signals are settled
  task automatic wait_for(input int chan, input string what);
    int n;
    n = 0;
    @(negedge clk);
    while (!chan_high(chan)) begin
      n++;
      if (n > TIMEOUT) stuck(what);
      @(negedge clk);
    end
  endtask

  task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, input axi_resp_e exp_resp);
    int              aw_gap;
    int              w_gap;
    int              aw_edge;
    int              w_edge;
    int              last_edge;
    int              hold;
    logic [ID_W-1:0] id;
    id     = ID_W'($urandom);
    aw_gap = int'($urandom_range(3, 0));
    w_gap  = int'($urandom_range(3, 0));
    fork
      begin
        repeat (aw_gap) next_cycle();
        awvalid = 1'b1;
        awid    = id;
        awaddr  = addr;
        wait_for(CH_AW, "write address handshake never completed");
        aw_edge = cyc + 1;
        next_cycle();
        awvalid = 1'b0;
      end
      begin
        repeat (w_gap) next_cycle();
        wvalid = 1'b1;
        wdata  = data;
        wstrb  = strb;
        wait_for(CH_W, "write data handshake never completed");
        w_edge = cyc + 1;
        next_cycle();
        wvalid = 1'b0;
      end
    join
    last_edge = (aw_edge > w_edge) ? aw_edge : w_edge;
    wait_for(CH_B, "write response never arrived");
    check_val("write latency", 32'd3, 32'(cyc - last_edge));
    check_val("bid", 32'(id), 32'(bid));
    check_val("bresp", 32'(exp_resp), 32'(bresp));
    hold = int'($urandom_range(5, 0));
    repeat (hold) begin
      @(negedge clk);
      check_true(bvalid, "bvalid dropped before bready");
      check_val("bid held", 32'(id), 32'(bid));
      check_val("bresp held", 32'(exp_resp), 32'(bresp));
    end
    next_cycle();
    bready = 1'b1;
    wait_for(CH_B, "write response handshake never completed");
    next_cycle();
    bready = 1'b0;
  endtask

  task automatic axi_read(input logic [31:0] addr, input axi_resp_e exp_resp,
                          output logic [31:0] data, output int ar_edge);
    int              hold;
    logic [ID_W-1:0] id;
    id = ID_W'($urandom);
    repeat (int'($urandom_range(3, 0))) next_cycle();
    arvalid = 1'b1;
    arid    = id;
    araddr  = addr;
    wait_for(CH_AR, "read address handshake never completed");
    ar_edge = cyc + 1;
    next_cycle();
    arvalid = 1'b0;
    wait_for(CH_R, "read data never arrived");
    check_val("read latency", 32'd3, 32'(cyc - ar_edge));
    check_val("rid", 32'(id), 32'(rid));
    check_val("rresp", 32'(exp_resp), 32'(rresp));
    check_true(rlast, "rlast low on a single-beat read");
    data = rdata;
    hold = int'($urandom_range(5, 0));
    repeat (hold) begin
      @(negedge clk);
      check_true(rvalid, "rvalid dropped before rready");
      check_val("rdata held", data, rdata);
      check_val("rid held", 32'(id), 32'(rid));
    end
    next_cycle();
    rready = 1'b1;
    wait_for(CH_R, "read data handshake never completed");
    next_cycle();
    rready = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // Model helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] hk_addr(input logic [19:0] off);
    return {12'h000, off};
  endfunction

  function automatic logic [31:0] buf_addr(input int word);
    return 32'h0010_0000 | (32'(word) << 2);
  endfunction

  function automatic logic [31:0] merge_lanes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  strb);
    logic [31:0] res;
    res = old_word;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) res[8*b +: 8] = new_word[8*b +: 8];
    end
    return res;
  endfunction

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    logic [31:0] data;
    logic [31:0] got;
    logic [31:0] c1;
    logic [31:0] c2;
    logic [3:0]  strb;
    logic [19:0] off;
    int          a1;
    int          a2;
    int          w;
    int          kind;

    void'($urandom(49));
    cyc = 0;
    errors = 0;
    checks = 0;
    tests_run = 0;
    tests_failed = 0;
    rst = 1'b1;
    awvalid = 1'b0;
    awid = '0;
    awaddr = '0;
    wvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    bready = 1'b0;
    arvalid = 1'b0;
    arid = '0;
    araddr = '0;
    rready = 1'b0;
    led_model = '0;
    scratch_model = '0;

    // Reset held for 10 cycles with nothing accepted
    start_test("reset");
    repeat (9) @(posedge clk);
    @(negedge clk);
    check_true(!(awready || wready || arready), "ready high during reset");
    check_true(!(bvalid || rvalid), "response valid during reset");
    next_cycle();
    rst = 1'b0;
    check_val("led_o", 32'd0, 32'(led));
    axi_read(hk_addr(20'h0), OKAY, got, a1);
    check_val("ID", ID_VALUE, got);
    end_test();

    start_test("hk_regs");
    for (int i = 0; i < 40; i++) begin
      kind = int'($urandom_range(3, 0));
      data = $urandom;
      case (kind)
        0: begin
          axi_write(hk_addr(20'h4), data, 4'($urandom), OKAY);
          led_model = data[7:0];
          check_val("led_o", 32'(led_model), 32'(led));
        end
        1: begin
          axi_write(hk_addr(20'h8), data, 4'($urandom), OKAY);
          scratch_model = data;
        end
        2: begin
          axi_read(hk_addr(20'h4), OKAY, got, a1);
          check_val("LED", 32'(led_model), got);
        end
        default: begin
          axi_read(hk_addr(20'h8), OKAY, got, a1);
          check_val("scratch", scratch_model, got);
        end
      endcase
    end
    axi_write(hk_addr(20'h0), $urandom, 4'hF, OKAY);
    axi_read(hk_addr(20'h0), OKAY, got, a1);
    check_val("ID after write", ID_VALUE, got);
    // A write to the counter must not disturb its count
    axi_read(hk_addr(20'hC), OKAY, c1, a1);
    axi_write(hk_addr(20'hC), 32'd0, 4'hF, OKAY);
    axi_read(hk_addr(20'hC), OKAY, c2, a2);
    check_val("counter after write", 32'(a2 - a1), c2 - c1);
    end_test();

    start_test("buf_ram");
    for (int i = 0; i < BUF_WORDS; i++) begin
      data = 32'h3C5A_0F96 ^ (32'(i) * 32'h0101_0101);
      axi_write(buf_addr(i), data, 4'hF, OKAY);
      ram_model[i] = data;
    end
    for (int i = 0; i < 200; i++) begin
      w    = int'($urandom_range(255, 0));
      data = $urandom;
      strb = 4'($urandom);
      axi_write(buf_addr(w), data, strb, OKAY);
      ram_model[w % BUF_WORDS] = merge_lanes(ram_model[w % BUF_WORDS], data, strb);
      // Read back through a random alias of the same word
      w = (w % BUF_WORDS) + BUF_WORDS * int'($urandom_range(3, 0));
      axi_read(buf_addr(w), OKAY, got, a1);
      check_val("RAM read-back", ram_model[w % BUF_WORDS], got);
    end
    for (int i = 0; i < BUF_WORDS; i++) begin
      axi_read(buf_addr(i), OKAY, got, a1);
      check_val("RAM sweep", ram_model[i], got);
    end
    end_test();

    start_test("unmapped");
    for (int r = 2; r < 16; r++) begin
      // Some offsets land on the LED and scratch registers
      case (r % 3)
        0:       off = 20'h0_0004;
        1:       off = 20'h0_0008;
        default: off = 20'($urandom) & 20'hF_FFFC;
      endcase
      axi_write({8'h00, 4'(r), off}, $urandom, 4'hF, SLVERR);
      axi_read({8'h00, 4'(r), off}, SLVERR, got, a1);
      check_val("unmapped rdata", 32'd0, got);
      w = int'(off[19:2]) % BUF_WORDS;
      axi_read(buf_addr(w), OKAY, got, a1);
      check_val("RAM untouched", ram_model[w], got);
    end
    axi_read(hk_addr(20'h4), OKAY, got, a1);
    check_val("LED untouched", 32'(led_model), got);
    axi_read(hk_addr(20'h8), OKAY, got, a1);
    check_val("scratch untouched", scratch_model, got);
    check_val("led_o untouched", 32'(led_model), 32'(led));
    end_test();

    start_test("counter");
    for (int i = 0; i < 5; i++) begin
      axi_read(hk_addr(20'hC), OKAY, c1, a1);
      repeat (int'($urandom_range(10, 0))) next_cycle();
      axi_read(hk_addr(20'hC), OKAY, c2, a2);
      check_val("counter step", 32'(a2 - a1), c2 - c1);
    end
    end_test();

    // Latency and hold checks sit inside the channel tasks
    start_test("backpressure");
    for (int i = 0; i < 30; i++) begin
      kind = int'($urandom_range(2, 0));
      data = $urandom;
      w    = int'($urandom_range(BUF_WORDS - 1, 0));
      if (kind == 0) begin
        axi_write(hk_addr(20'h8), data, 4'hF, OKAY);
        scratch_model = data;
      end else if (kind == 1) begin
        axi_read(hk_addr(20'h8), OKAY, got, a1);
        check_val("scratch", scratch_model, got);
      end else begin
        axi_read(buf_addr(w), OKAY, got, a1);
        check_val("RAM", ram_model[w], got);
      end
    end
    end_test();

    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- ps_bus.f
design/axi_bus_pkg.sv
design/sys_bus_pkg.sv
design/sys_bus_if.sv
design/axi4_slave.sv
design/sys_bus_interconnect.sv
design/housekeeping_regs.sv
design/buffer_ram.sv
design/ps_bus_top.sv
dv/ps_bus_tb.sv

//--- Makefile
SIM       ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= ps_bus_tb
RTL_TOP   ?= ps_bus_top
FILELIST  ?= ps_bus.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Something failed

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation FAILED, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(SIM) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)
	$(SIM) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
